/* build.f */
common/isa_pkg.sv
common/core_pkg.sv
execute/alu.sv
execute/commit_unit.sv
verilog/program_counter.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/pat_core.sv
tests/tb_pat_core.sv

/* common/core_pkg.sv */
package core_pkg;

	// datapath sizes
	localparam int d_w = 8;
	localparam int reg_adr_w = 3;
	localparam int num_regs = 1 << reg_adr_w;	// eight data registers
	localparam int pc_w = 10;	// 1k word program space
	localparam int shamt_w = 3;	// shift amount taken from low bits of b

	// ======================================================================
	// alu operation codes
	// ======================================================================
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t alu_or = 4'd0;
	localparam alu_op_t alu_and = 4'd1;
	localparam alu_op_t alu_add = 4'd2;
	localparam alu_op_t alu_sub = 4'd3;
	localparam alu_op_t alu_pass_b = 4'd4;	// ldi
	localparam alu_op_t alu_not = 4'd5;
	localparam alu_op_t alu_shlz = 4'd6;
	localparam alu_op_t alu_shlo = 4'd7;	// shift left, ones in
	localparam alu_op_t alu_shrz = 4'd8;
	localparam alu_op_t alu_asr = 4'd9;

	// decode to execute, one register stage
	typedef struct packed {
		logic valid;	// cleared for nop, spare codes and squashed slots
		alu_op_t alu_op;
		logic [reg_adr_w-1:0] rd;
		logic [d_w-1:0] a;	// rn contents, bypassed
		logic [d_w-1:0] b;	// immediate or second register
		logic wr_en;
		logic is_test;
		logic is_out;
		logic is_branch;
		logic [isa_pkg::cond_w-1:0] cond;
		logic [pc_w-1:0] branch_target;
	} dec_op_t;

	// commit to register file
	typedef struct packed {
		logic en;
		logic [reg_adr_w-1:0] adr;
		logic [d_w-1:0] data;
	} wb_t;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

	// ======================================================================
	// instruction word layout
	// ======================================================================
	localparam int instr_w = 17;	// full instruction word
	localparam int rn_w = 3;	// source/destination register field
	localparam int cond_w = 2;	// condition field
	localparam int opc_w = 4;	// opcode width, same in all three formats
	localparam int imm8_w = 8;
	localparam int imm3_w = 3;

	// i8 opcodes, even code is the immediate form and odd the register form
	localparam logic [opc_w-1:0] op_ori = 4'd0;
	localparam logic [opc_w-1:0] op_orr = 4'd1;
	localparam logic [opc_w-1:0] op_andi = 4'd2;
	localparam logic [opc_w-1:0] op_andr = 4'd3;
	localparam logic [opc_w-1:0] op_addi = 4'd4;
	localparam logic [opc_w-1:0] op_addr = 4'd5;
	localparam logic [opc_w-1:0] op_subi = 4'd6;
	localparam logic [opc_w-1:0] op_subr = 4'd7;
	localparam logic [opc_w-1:0] op_ldi = 4'd8;
	localparam logic [opc_w-1:0] op_bf = 4'd13;	// pc relative, signed imm8
	localparam logic [opc_w-1:0] op_prefix = 4'd15;	// escapes into i3 space

	// i3 opcodes, sub_reg picks register amount over imm3
	localparam logic [opc_w-1:0] op3_shlz = 4'd0;
	localparam logic [opc_w-1:0] op3_shlo = 4'd1;
	localparam logic [opc_w-1:0] op3_shrz = 4'd2;
	localparam logic [opc_w-1:0] op3_asr = 4'd3;
	localparam logic [opc_w-1:0] op3_out = 4'd11;
	localparam logic [opc_w-1:0] op3_prefix = 4'd15;	// escapes into i0 space

	// i0 opcodes live in the low nibble
	localparam logic [opc_w-1:0] op0_not = 4'd0;
	localparam logic [opc_w-1:0] op0_test = 4'd2;
	localparam logic [opc_w-1:0] op0_nop = 4'd15;

	// condition codes
	localparam logic [cond_w-1:0] cond_z = 2'd0;
	localparam logic [cond_w-1:0] cond_nz = 2'd1;	// not zero
	localparam logic [cond_w-1:0] cond_n = 2'd2;
	localparam logic [cond_w-1:0] cond_al = 2'd3;

	// i8 view
	typedef struct packed {
		logic [rn_w-1:0] rn;
		logic [cond_w-1:0] cond;
		logic [opc_w-1:0] opcode;
		logic [imm8_w-1:0] imm8;
	} i8_fmt_t;

	// short view, shared by the i3 and i0 forms
	typedef struct packed {
		logic [rn_w-1:0] rn;
		logic [cond_w-1:0] cond;
		logic [opc_w-1:0] prefix;	// op_prefix here
		logic [opc_w-1:0] sub_opcode;
		logic sub_reg;
		logic [imm3_w-1:0] imm3;
	} short_fmt_t;

	typedef union packed {
		i8_fmt_t i8;
		short_fmt_t sh;
	} instr_t;

	// always-executed nop, both prefixes then op0_nop
	localparam logic [instr_w-1:0] instr_nop =
		{{rn_w{1'b0}}, cond_al, op_prefix, op3_prefix, op0_nop};

endpackage

/* execute/alu.sv */
`timescale 1ns/100ps

// combinational alu
// a is always rn, b is the immediate or second register
module alu
(
	input core_pkg::alu_op_t i_op,
	input logic [core_pkg::d_w-1:0] i_a,
	input logic [core_pkg::d_w-1:0] i_b,
	output logic [core_pkg::d_w-1:0] o_y
);
	import core_pkg::*;

	logic sub;	// subtract through the shared adder
	logic [d_w-1:0] addsub;
	logic [shamt_w-1:0] shamt;
	logic [d_w-1:0] fill;	// low ones for shlo

	// one adder for add and sub, invert b and carry in one
	assign sub = (i_op == alu_sub);
	assign addsub = i_a + (sub ? ~i_b : i_b) + d_w'(sub);	// wraps at 8 bits

	// shifts only look at the bottom three bits of b
	assign shamt = i_b[shamt_w-1:0];

	// ones in the bits vacated by a left shift of shamt
	assign fill = ~({d_w{1'b1}} << shamt);

	always_comb
	begin
		case (i_op)
			alu_or: o_y = i_a | i_b;
			alu_and: o_y = i_a & i_b;
			alu_add, alu_sub: o_y = addsub;
			alu_pass_b: o_y = i_b;	// load immediate
			alu_not: o_y = ~i_a;
			alu_shlz: o_y = i_a << shamt;
			alu_shlo: o_y = (i_a << shamt) | fill;
			alu_shrz: o_y = i_a >> shamt;
			alu_asr:
			begin
				// sign bit copied into the top
				o_y = $signed(i_a) >>> shamt;
			end
			default: o_y = '0;	// spare codes
		endcase
	end

endmodule

/* execute/commit_unit.sv */
`timescale 1ns/100ps

// execute stage commit
// condition check, flags, out port, write-back and branch resolution
module commit_unit
(
	input logic clk,
	input logic reset,
	input core_pkg::dec_op_t i_dec,
	input logic [core_pkg::d_w-1:0] i_result,	// alu output
	output core_pkg::wb_t o_wb,
	output logic o_redirect,
	output logic [core_pkg::pc_w-1:0] o_target,
	output logic [core_pkg::d_w-1:0] o_out,
	output logic o_out_valid
);
	import core_pkg::*;
	import isa_pkg::*;

	logic z;	// set by test only
	logic n;
	logic cond_ok;
	logic exec_ok;	// valid slot whose condition holds

	// ======================================================================
	// condition and write-back
	// ======================================================================
	// every instruction is conditional on the registered flags
	always_comb
	begin
		case (i_dec.cond)
			cond_z: cond_ok = z;
			cond_nz: cond_ok = !z;
			cond_n: cond_ok = n;
			cond_al: cond_ok = 1'b1;
		endcase
	end

	assign exec_ok = i_dec.valid && cond_ok;

	always_comb
	begin
		o_wb.en = exec_ok && i_dec.wr_en;
		o_wb.adr = i_dec.rd;
		o_wb.data = i_result;
	end

	// taken branch redirects fetch right away
	assign o_redirect = exec_ok && i_dec.is_branch;
	assign o_target = i_dec.branch_target;

	// ======================================================================
	// flags and out port
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z <= 1'b0;
			n <= 1'b0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_out_valid <= exec_ok && i_dec.is_out;	// one cycle strobe
			if (exec_ok && i_dec.is_test)
			begin
				z <= (i_dec.a == '0);
				n <= i_dec.a[d_w-1];	// sign of rn
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (exec_ok && i_dec.is_out)
		begin
			o_out <= i_dec.a;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the pat_core testbench with verilator
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pat_core -f build.f \
	--Mdir "$obj_dir" -o tb_pat_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj_dir/tb_pat_core" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "^TEST PASSED$" "$log"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see $log"
exit 1

/* tests/pat_core_vectors.txt */
# P <word address hex> <17 bit instruction hex>, loaded into the program store
# E <expected o_out hex>, in the order the out strobes must appear
P 00 0785A  # ldi r1, 5a
P 01 07081  # ori r1, 81
P 02 07FB0  # out r1
P 03 0723C  # andi r1, 3c
P 04 074F0  # addi r1, f0, wraps
P 05 07FB0  # out r1
P 06 07610  # subi r1, 10, wraps
P 07 0B80F  # ldi r2, 0f
P 08 07102  # orr r1, r2
P 09 07FB0  # out r1
P 0a 07302  # andr r1, r2
P 0b 07502  # addr r1, r2
P 0c 07FB0  # out r1
P 0d 07702  # subr r1, r2
P 0e 07FB0  # out r1
P 0f 0F87F  # ldi r3, 7f
P 10 0F401  # addi r3, 01, bypassed
P 11 0FFB0  # out r3
P 12 138B5  # ldi r4, b5
P 13 13F02  # shlz r4, #2
P 14 13FB0  # out r4
P 15 13F13  # shlo r4, #3
P 16 13FB0  # out r4
P 17 1B802  # ldi r6, 02
P 18 13F3E  # asr r4, r6
P 19 13FB0  # out r4
P 1a 13F2E  # shrz r4, r6
P 1b 13FB0  # out r4
P 1c 13FF0  # not r4
P 1d 13FB0  # out r4
P 1e 13FF2  # test r4, n set
P 1f 02D03  # bf n +3, taken
P 20 13FB0  # out r4, squashed
P 21 0FFB0  # out r3, never fetched
P 22 00D03  # bf z +3, not taken
P 23 0FFB0  # out r3
P 24 01D02  # bf nz +2, taken
P 25 13FB0  # out r4, squashed
P 26 17803  # ldi r5, 03
P 27 17FB0  # out r5, loop head
P 28 17601  # subi r5, 01
P 29 17FF2  # test r5
P 2a 01DFD  # bf nz -3
P 2b 17FB0  # out r5, only after the loop
P 2c 00D02  # bf z +2, taken
P 2d 13FB0  # out r4, squashed
P 2e 03D00  # bf al 0, park
E DB
E 08
E FF
E 1E
E 0F
E 80
E D4
E A7
E E9
E 3A
E C5
E 80
E 03
E 02
E 01
E 00

/* tests/tb_pat_core.sv */
`timescale 1ns/100ps

module tb_pat_core;
	import core_pkg::*;
	import isa_pkg::*;

	localparam int mem_words = 1 << pc_w;	// whole program space
	localparam string vec_file = "tests/pat_core_vectors.txt";

	logic clk;
	logic reset;
	instr_t instr;
	logic [pc_w-1:0] pc;
	logic [d_w-1:0] out_data;
	logic out_valid;
	logic jump;	// taken branch strobe

	logic [instr_w-1:0] prog_mem [mem_words];	// program store model
	logic [d_w-1:0] exp_vals [$];	// out values in the order they must appear
	int n_words = 0;
	int exp_idx = 0;	// next expected value
	int cycle_cnt = 0;
	int cycle_limit = 200;

	// fetch tracking for the pc and jump checks
	logic [pc_w-1:0] prev_pc;	// fetch address one cycle back
	logic prev_live;	// word fetched one cycle back reaches execute
	logic [pc_w-1:0] exp_pc;	// o_pc due in the next cycle
	logic pc_known = 1'b0;

	pat_core i_pat_core
	(
		.clk(clk),
		.reset(reset),
		.o_pc(pc),
		.i_instr(instr),
		.o_out(out_data),
		.o_out_valid(out_valid),
		.o_jump(jump)
	);

	// program store answers o_pc in the same cycle
	assign instr = prog_mem[pc];

	// ======================================================================
	// helpers
	// ======================================================================
	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			stop_run($sformatf("[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, got, exp));
		end
	endtask

	// i8 opcode of the stored word
	function automatic logic [opc_w-1:0] opcode_at(input logic [pc_w-1:0] adr);
		instr_t word;
		word = prog_mem[adr];
		return word.i8.opcode;
	endfunction

	// bf destination, word address plus signed imm8
	function automatic logic [pc_w-1:0] bf_target(input logic [pc_w-1:0] adr);
		instr_t word;
		word = prog_mem[adr];
		return adr + pc_w'($signed(word.i8.imm8));
	endfunction

	// P lines fill the program store, E lines queue expected out values
	task automatic load_vectors();
		int fd;
		int code;
		string line;
		logic [31:0] adr;
		logic [31:0] val;
		for (int i = 0; i < mem_words; i++)
		begin
			prog_mem[i] = instr_nop;	// unloaded words do nothing
		end
		fd = $fopen(vec_file, "r");
		if (fd == 0)
		begin
			stop_run("could not open the vector file tests/pat_core_vectors.txt");
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 0)
			begin
				if (line[0] == "P")
				begin
					code = $sscanf(line, "P %h %h", adr, val);
					if (code == 2)
					begin
						prog_mem[adr[pc_w-1:0]] = val[instr_w-1:0];
						n_words++;
					end
				end
				else if (line[0] == "E")
				begin
					code = $sscanf(line, "E %h", val);
					if (code == 1)
					begin
						exp_vals.push_back(val[d_w-1:0]);
					end
				end
			end
		end
		$fclose(fd);
		if (n_words == 0 || exp_vals.size() == 0)
		begin
			stop_run("vector file holds no program words or no expected values");
		end
		cycle_limit = 4 * n_words + 200;	// generous bound on run length
	endtask

	// ======================================================================
	// clock, timeout and out monitor
	// ======================================================================
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			stop_run($sformatf("timeout after %0d cycles, saw %0d of %0d out values",
				cycle_cnt, exp_idx, exp_vals.size()));
		end
	end

	// outputs sampled mid cycle, away from the rising edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			pc_known = 1'b0;
			prev_live = 1'b0;	// first slot after reset is a nop
			if (cycle_cnt > 0)
			begin
				check_value(32'(out_valid), 32'd0, "o_out_valid during reset");
			end
		end
		else
		begin
			if (out_valid)
			begin
				if (exp_idx >= exp_vals.size())
				begin
					stop_run($sformatf("an extra out strobe appeared with o_out = %0h",
						out_data));
				end
				else
				begin
					check_value(32'(out_data), 32'(exp_vals[exp_idx]),
						$sformatf("out value %0d", exp_idx));
					exp_idx++;
				end
			end
			// fetch steps by one unless a taken bf redirected it last cycle
			if (pc_known)
			begin
				check_value(32'(pc), 32'(exp_pc), "o_pc sequence");
			end
			if (jump)
			begin
				check_value(32'(prev_live), 32'd1, "o_jump with a squashed slot in execute");
				check_value(32'(opcode_at(prev_pc)), 32'(op_bf), "o_jump on a word that is not bf");
				exp_pc = bf_target(prev_pc);
			end
			else
			begin
				exp_pc = pc + 1'b1;
			end
			prev_pc = pc;
			prev_live = !jump;	// a taken branch drops the word fetched alongside it
			pc_known = 1'b1;
		end
	end

	// ======================================================================
	// main sequence
	// ======================================================================
	initial
	begin
		reset <= 1'b1;
		load_vectors();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value(32'(pc), 32'd0, "o_pc after reset");	// first fetch from word 0
		check_value(32'(out_valid), 32'd0, "o_out_valid after reset");
		while (exp_idx < exp_vals.size())
		begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);	// program is parked, no more strobes allowed
		if (exp_idx == exp_vals.size())
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
		begin
			stop_run("out values still missing at the end of the run");
		end
	end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/100ps

// decode and register read
module instr_decoder
(
	input logic clk,
	input logic reset,
	input isa_pkg::instr_t i_instr,
	input logic [core_pkg::pc_w-1:0] i_pc,	// address i_instr came from
	input logic i_squash,	// taken branch, drop this slot
	output logic [core_pkg::reg_adr_w-1:0] o_rd_adr_a,
	output logic [core_pkg::reg_adr_w-1:0] o_rd_adr_b,
	input logic [core_pkg::d_w-1:0] i_rd_data_a,
	input logic [core_pkg::d_w-1:0] i_rd_data_b,
	output core_pkg::dec_op_t o_dec
);
	import core_pkg::*;
	import isa_pkg::*;

	instr_t slot;	// word actually decoded
	logic is_i8;
	logic is_i3;
	logic [pc_w-1:0] br_ofs;	// sign extended imm8
	dec_op_t dec_next;

	// register addresses come straight from the fetched word
	// imm8 low bits and imm3 are the same three bits of the word
	assign o_rd_adr_a = i_instr.i8.rn;
	assign o_rd_adr_b = i_instr.sh.imm3;

	// reset and squash turn the slot into a nop, which decodes invalid
	assign slot = (reset || i_squash) ? instr_t'(instr_nop) : i_instr;

	assign is_i8 = (slot.i8.opcode != op_prefix);
	assign is_i3 = !is_i8 && (slot.sh.sub_opcode != op3_prefix);
	assign br_ofs = {{(pc_w-imm8_w){slot.i8.imm8[imm8_w-1]}}, slot.i8.imm8};

	// ======================================================================
	// format and opcode decode
	// ======================================================================
	always_comb
	begin
		dec_next = '0;
		dec_next.rd = slot.i8.rn;	// rn is both source a and destination
		dec_next.cond = slot.i8.cond;
		dec_next.a = i_rd_data_a;
		dec_next.branch_target = i_pc + br_ofs;
		if (is_i8)
		begin
			// odd opcode takes the register named by imm8
			dec_next.b = slot.i8.opcode[0] ? i_rd_data_b : d_w'(slot.i8.imm8);
			dec_next.valid = 1'b1;
			dec_next.wr_en = 1'b1;
			case (slot.i8.opcode)
				op_ori, op_orr: dec_next.alu_op = alu_or;
				op_andi, op_andr: dec_next.alu_op = alu_and;
				op_addi, op_addr: dec_next.alu_op = alu_add;
				op_subi, op_subr: dec_next.alu_op = alu_sub;
				op_ldi: dec_next.alu_op = alu_pass_b;
				op_bf:
				begin
					dec_next.wr_en = 1'b0;
					dec_next.is_branch = 1'b1;
				end
				default: dec_next.valid = 1'b0;	// spare i8 codes do nothing
			endcase
		end
		else if (is_i3)
		begin
			dec_next.b = slot.sh.sub_reg ? i_rd_data_b : d_w'(slot.sh.imm3);
			dec_next.valid = 1'b1;
			dec_next.wr_en = 1'b1;
			case (slot.sh.sub_opcode)
				op3_shlz: dec_next.alu_op = alu_shlz;
				op3_shlo: dec_next.alu_op = alu_shlo;
				op3_shrz: dec_next.alu_op = alu_shrz;
				op3_asr: dec_next.alu_op = alu_asr;
				op3_out:
				begin
					dec_next.wr_en = 1'b0;
					dec_next.is_out = 1'b1;	// value travels on a
				end
				default: dec_next.valid = 1'b0;
			endcase
		end
		else
		begin
			// i0, opcode in the low nibble
			case (slot.i8.imm8[opc_w-1:0])
				op0_not:
				begin
					dec_next.valid = 1'b1;
					dec_next.wr_en = 1'b1;
					dec_next.alu_op = alu_not;
				end
				op0_test:
				begin
					dec_next.valid = 1'b1;
					dec_next.is_test = 1'b1;
				end
				default: dec_next.valid = 1'b0;	// op0_nop and spares
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		o_dec <= dec_next;
	end

endmodule

/* verilog/pat_core.sv */
`timescale 1ns/100ps

// two stage core
// stage 1 fetch/decode/register read, stage 2 alu and commit
module pat_core
(
	input logic clk,
	input logic reset,
	output logic [core_pkg::pc_w-1:0] o_pc,	// word address to program store
	input isa_pkg::instr_t i_instr,	// word at o_pc, same cycle
	output logic [core_pkg::d_w-1:0] o_out,
	output logic o_out_valid,
	output logic o_jump	// taken branch in execute
);
	import core_pkg::*;

	dec_op_t dec;	// decode -> execute
	wb_t wb;	// commit -> register file
	logic [reg_adr_w-1:0] rd_adr_a;
	logic [reg_adr_w-1:0] rd_adr_b;
	logic [d_w-1:0] rd_data_a;
	logic [d_w-1:0] rd_data_b;
	logic [d_w-1:0] alu_y;
	logic redirect;
	logic [pc_w-1:0] target;

	assign o_jump = redirect;

	// ======================================================================
	// fetch and decode
	// ======================================================================
	program_counter i_program_counter (.clk(clk), .reset(reset), .i_redirect(redirect),
		.i_target(target), .o_pc(o_pc));

	instr_decoder i_instr_decoder (.clk(clk), .reset(reset), .i_instr(i_instr), .i_pc(o_pc),
		.i_squash(redirect), .o_rd_adr_a(rd_adr_a), .o_rd_adr_b(rd_adr_b),
		.i_rd_data_a(rd_data_a), .i_rd_data_b(rd_data_b), .o_dec(dec));

	register_file i_register_file (.clk(clk), .i_adr_a(rd_adr_a), .i_adr_b(rd_adr_b),
		.o_data_a(rd_data_a), .o_data_b(rd_data_b), .i_wb(wb));

	// ======================================================================
	// execute and commit
	// ======================================================================
	alu i_alu (.i_op(dec.alu_op), .i_a(dec.a), .i_b(dec.b), .o_y(alu_y));

	commit_unit i_commit_unit (.clk(clk), .reset(reset), .i_dec(dec), .i_result(alu_y),
		.o_wb(wb), .o_redirect(redirect), .o_target(target), .o_out(o_out),
		.o_out_valid(o_out_valid));

endmodule

/* verilog/program_counter.sv */
`timescale 1ns/100ps

// fetch address
// steps by one word per cycle, loads the target after a taken branch
module program_counter
(
	input logic clk,
	input logic reset,
	input logic i_redirect,	// taken bf in execute this cycle
	input logic [core_pkg::pc_w-1:0] i_target,
	output logic [core_pkg::pc_w-1:0] o_pc
);
	import core_pkg::*;

	logic [pc_w-1:0] pc_next;

	// the redirect wins over the increment
	// the slot fetched alongside it is dropped by the decoder
	always_comb
	begin
		if (i_redirect)
		begin
			pc_next = i_target;
		end
		else
		begin
			pc_next = o_pc + 1'b1;	// wraps at the top of program space
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= '0;	// programs start at word 0
		end
		else
		begin
			o_pc <= pc_next;
		end
	end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/100ps

// eight data registers, one write port and two read ports
module register_file
(
	input logic clk,
	input logic [core_pkg::reg_adr_w-1:0] i_adr_a,
	input logic [core_pkg::reg_adr_w-1:0] i_adr_b,
	output logic [core_pkg::d_w-1:0] o_data_a,
	output logic [core_pkg::d_w-1:0] o_data_b,
	input core_pkg::wb_t i_wb	// from commit, same cycle as execute
);
	import core_pkg::*;

	logic [d_w-1:0] regs [num_regs];

	// forward the write in flight when it targets the register being read
	// lets a dependent instruction follow directly behind its producer
	function automatic logic [d_w-1:0] bypass
	(
		input logic [reg_adr_w-1:0] adr,
		input logic [d_w-1:0] stored,
		input wb_t wb
	);
		if (wb.en && (wb.adr == adr))
		begin
			return wb.data;
		end
		return stored;
	endfunction

	assign o_data_a = bypass(i_adr_a, regs[i_adr_a], i_wb);
	assign o_data_b = bypass(i_adr_b, regs[i_adr_b], i_wb);

	always_ff @(posedge clk)
	begin
		if (i_wb.en)
		begin
			regs[i_wb.adr] <= i_wb.data;
		end
	end

endmodule
